// File: vidgen_subsystem.f
+incdir+.
vidgen_pkg.sv
sync_pulse_gen.sv
sync_to_blanking.sv
blanking_to_count.sv
clut_palette.sv
vidgen_subsystem.sv
tb_vidgen_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f vidgen_subsystem.f \
	--top-module tb_vidgen_subsystem \
	-o sim_vidgen

./obj_dir/sim_vidgen | tee sim.log

if grep -q 'All tests passed!' sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

// File: tb_vidgen_subsystem.sv
`default_nettype none

`include "vidgen_defines.svh"

module tb_vidgen_subsystem;

	import vidgen_pkg::*;

	localparam int          CLK_PERIOD = 100;
	localparam int          RST_CYCLES = 8;
	localparam int          FRAME      = `VID_TOTAL_COLS * `VID_TOTAL_ROWS;
	localparam int          ACT_DOTS   = `VID_ACTIVE_COLS * `VID_ACTIVE_ROWS;
	// Bank 1 from this active row down
	localparam int          BANK_ROW   = `VID_ACTIVE_ROWS / 2;
	localparam int          MAX_ERRS   = 10;
	localparam logic [31:0] LFSR_SEED  = 32'h887c;

	// DUT side
	logic                  clk;
	logic                  rst_n;
	logic [`VID_DOT_W-1:0] dot;
	logic                  bank;
	logic                  pal_wr_stb;
	pal_wr_t               pal_wr;
	video_pos_t            pos;
	logic                  locked;
	rgb_t                  rgb;
	logic                  hsync_n;
	logic                  vsync_n;
	logic                  csync_n;

	// Reference palette, mirrors every write
	rgb_t                   model_pal [1 << `VID_PAL_AW];
	logic [31:0]            lfsr = LFSR_SEED;
	rgb_t                   rgb_exp_now = '0;
	rgb_t                   rgb_exp_next = '0;
	logic                   prev_active = 1'b0;
	logic                   csync_on = 1'b0;
	logic                   colour_on = 1'b0;
	logic                   hold_dot_en = 1'b0;
	logic [`VID_PAL_AW-1:0] hold_addr = '0;
	logic                   wr_req = 1'b0;
	pal_wr_t                wr_req_data = '0;
	int                     cycles = 0;
	int                     lock_cycle = -1;
	int                     cur_errors = 0;
	int                     pass_count = 0;
	int                     fail_count = 0;
	string                  cur_test = "";

	always #(CLK_PERIOD / 2) clk = ~clk;

	vidgen_subsystem u_vidgen_subsystem (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_dot        (dot),
		.i_bank       (bank),
		.i_pal_wr_stb (pal_wr_stb),
		.i_pal_wr     (pal_wr),
		.o_pos        (pos),
		.o_locked     (locked),
		.o_rgb        (rgb),
		.o_hsync_n    (hsync_n),
		.o_vsync_n    (vsync_n),
		.o_csync_n    (csync_n)
	);

	////////////////////
	// Helpers
	////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit, new bit enters at the bottom
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic compare_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected == actual)
		else begin
			$display("Error: %s %s expected %0d actual %0d", cur_test, what, expected, actual);
			cur_errors++;
		end
	endtask

	task automatic confirm(input logic cond, input string what);
		assert (cond)
		else begin
			$display("%s: %s", cur_test, what);
			cur_errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test   = name;
		cur_errors = 0;
	endtask

	task automatic end_test();
		if (cur_errors == 0) begin
			pass_count++;
			$display("PASS %s", cur_test);
		end else begin
			fail_count++;
			$display("FAIL %s with %0d errors", cur_test, cur_errors);
		end
	endtask

	// Clock, sample the outputs, then drive the next inputs
	task automatic next_cycle();
		logic [15:0] r;
		prev_active = pos.active;
		@(posedge clk);
		#1;
		rgb_exp_now = rgb_exp_next;
		if (rst_n)
			cycles++;
		if (locked && lock_cycle < 0)
			lock_cycle = cycles;
		if (csync_on)
			confirm(csync_n == (hsync_n & vsync_n), "o_csync_n is not hsync_n AND vsync_n");
		if (colour_on)
			compare_value("o_rgb", 32'(rgb_exp_now), 32'(rgb));
		// Random dot on active cycles, bank by row half
		if (pos.active) begin
			take_bits(`VID_DOT_W, r);
			dot  = r[`VID_DOT_W-1:0];
			bank = (32'(pos.row) >= BANK_ROW);
			if (hold_dot_en)
				{bank, dot} = hold_addr;
		end else begin
			dot  = '0;
			bank = 1'b0;
		end
		// Seen on o_rgb after the next edge
		rgb_exp_next = pos.active ? model_pal[{bank, dot}] : '0;
		// Model takes the write only after this lookup
		pal_wr_stb = wr_req;
		pal_wr     = wr_req_data;
		if (wr_req)
			model_pal[wr_req_data.addr] = wr_req_data.color;
		wr_req = 1'b0;
	endtask

	// Until the given active dot shows on o_pos
	task automatic wait_pixel(input int row, input int col, input int limit, output logic ok);
		ok = 1'b0;
		for (int n = 0; n < limit && !ok; n++) begin
			next_cycle();
			ok = pos.active && (32'(pos.row) == row) && (32'(pos.col) == col);
		end
	endtask

	// Fall to rise and fall to next fall of one sync
	task automatic measure_pulse(input logic use_v, input int limit, output int low_len,
			output int period, output logic ok);
		logic was;
		logic now;
		int   fall_at;
		ok      = 1'b0;
		low_len = 0;
		period  = 0;
		fall_at = -1;
		for (int n = 0; n < limit && !ok; n++) begin
			was = use_v ? vsync_n : hsync_n;
			next_cycle();
			now = use_v ? vsync_n : hsync_n;
			if (was && !now && fall_at >= 0) begin
				period = n - fall_at;
				ok     = 1'b1;
			end else if (was && !now)
				fall_at = n;
			else if (!was && now && fall_at >= 0)
				low_len = n - fall_at;
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		logic [15:0] r;
		logic        ok;
		int          low_len;
		int          period;
		int          act_total;
		int          lines;
		int          exp_col;
		int          banked [2];
		rgb_t        old_val;
		rgb_t        new_val;
		clk        = 1'b0;
		rst_n      = 1'b0;
		dot        = '0;
		bank       = 1'b0;
		pal_wr_stb = 1'b0;
		pal_wr     = '0;

		// Palette fill begins under reset and runs on after release
		for (int k = 0; k < (1 << `VID_PAL_AW); k++) begin
			take_bits(`VID_COMP_W * 3, r);
			wr_req      = 1'b1;
			wr_req_data = '{addr: `VID_PAL_AW'(k), color: r[11:0]};
			next_cycle();
			if (k == RST_CYCLES - 1)
				rst_n = 1'b1;
		end

		// Line period and pulse width
		start_test("hsync");
		csync_on = 1'b1;
		for (int i = 0; i < 4; i++) begin
			measure_pulse(1'b0, 3 * `VID_TOTAL_COLS, low_len, period, ok);
			confirm(ok, "timed out waiting for two hsync falling edges");
			if (ok) begin
				compare_value("low cycles", `VID_HSYNC_W, low_len);
				compare_value("fall to fall cycles", `VID_TOTAL_COLS, period);
			end
		end
		end_test();

		start_test("vsync");
		measure_pulse(1'b1, 2 * FRAME + `VID_TOTAL_COLS, low_len, period, ok);
		confirm(ok, "timed out waiting for two vsync falling edges");
		if (ok) begin
			compare_value("low cycles", `VID_VSYNC_W * `VID_TOTAL_COLS, low_len);
			compare_value("fall to fall cycles", FRAME, period);
		end
		csync_on = 1'b0;
		end_test();

		// Rise time comes from next_cycle, it may already be logged
		start_test("lock");
		while (lock_cycle < 0 && cycles <= 2 * FRAME)
			next_cycle();
		confirm(lock_cycle >= 0 && lock_cycle <= 2 * FRAME,
			"o_locked did not rise within two frames of reset");
		if (lock_cycle >= 0) begin
			for (int n = 0; n < 2 * FRAME && locked; n++)
				next_cycle();
			confirm(locked, "o_locked dropped during the two frames after lock");
		end
		end_test();

		// One frame window from the first active dot
		start_test("active area");
		wait_pixel(0, 0, 2 * FRAME, ok);
		confirm(ok, "timed out waiting for the first active dot of a frame");
		act_total = 0;
		lines     = 0;
		exp_col   = 0;
		for (int n = 0; ok && n < FRAME && cur_errors < MAX_ERRS; n++) begin
			if (n > 0)
				next_cycle();
			if (pos.active) begin
				exp_col = prev_active ? exp_col + 1 : 0;
				act_total++;
				compare_value("col", exp_col, 32'(pos.col));
				compare_value("row", lines, 32'(pos.row));
			end else begin
				// Line just closed
				if (prev_active) begin
					compare_value("last col", `VID_ACTIVE_COLS - 1, exp_col);
					lines++;
				end
				compare_value("col outside active", 0, 32'(pos.col));
				compare_value("row outside active", 0, 32'(pos.row));
			end
		end
		if (ok) begin
			compare_value("active lines", `VID_ACTIVE_ROWS, lines);
			compare_value("active cycles per frame", ACT_DOTS, act_total);
		end
		end_test();

		// Every cycle checked in next_cycle, both bank halves counted
		start_test("colour lookup");
		colour_on = 1'b1;
		banked[0] = 0;
		banked[1] = 0;
		wait_pixel(0, 0, 2 * FRAME, ok);
		confirm(ok, "timed out waiting for the first active dot of a frame");
		for (int n = 0; ok && n < FRAME && cur_errors < MAX_ERRS; n++) begin
			if (n > 0)
				next_cycle();
			if (pos.active)
				banked[bank]++;
		end
		compare_value("bank 0 dots", ACT_DOTS / 2, banked[0]);
		compare_value("bank 1 dots", ACT_DOTS / 2, banked[1]);
		end_test();

		// Write lands with the dot on screen, old then new colour
		start_test("palette write");
		wait_pixel(60, 99, 2 * FRAME, ok);
		confirm(ok, "timed out waiting for the write position");
		if (ok) begin
			hold_dot_en = 1'b1;
			hold_addr   = {1'b0, 8'h5a};
			old_val     = model_pal[hold_addr];
			new_val     = old_val ^ 12'hfff;
			wr_req      = 1'b1;
			wr_req_data = '{addr: hold_addr, color: new_val};
			next_cycle();
			next_cycle();
			compare_value("rgb in write cycle", 32'(old_val), 32'(rgb));
			hold_dot_en = 1'b0;
			next_cycle();
			compare_value("rgb after write", 32'(new_val), 32'(rgb));
		end
		colour_on = 1'b0;
		end_test();

		$display("Tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: vidgen_subsystem.sv
`default_nettype none

`include "vidgen_defines.svh"

module vidgen_subsystem (
	input  wire logic                   i_clk,
	input  wire logic                   i_rst_n,
	input  wire logic [`VID_DOT_W-1:0]  i_dot,
	input  wire logic                   i_bank,
	input  wire logic                   i_pal_wr_stb,
	input  wire vidgen_pkg::pal_wr_t    i_pal_wr,
	output vidgen_pkg::video_pos_t      o_pos,
	output logic                        o_locked,
	output vidgen_pkg::rgb_t            o_rgb,
	output logic                        o_hsync_n,
	output logic                        o_vsync_n,
	output logic                        o_csync_n
);

	import vidgen_pkg::*;

	// One register stage between each
	video_timing_t t1;
	video_timing_t t2;
	video_timing_t t3;
	video_timing_t t4;

	////////////////////
	// Timing chain
	////////////////////

	// Raw sync pulses only
	sync_pulse_gen u_sync_pulse_gen (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.o_timing (t1)
	);

	// Blanking rebuilt from the sync edges
	sync_to_blanking u_sync_to_blanking (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_timing (t1),
		.o_timing (t2)
	);

	// Lock plus active position, o_pos in step with t3
	blanking_to_count u_blanking_to_count (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_timing (t2),
		.o_timing (t3),
		.o_pos    (o_pos),
		.o_locked (o_locked)
	);

	////////////////////
	// Colour output
	////////////////////

	clut_palette u_clut_palette (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_timing     (t3),
		.i_active     (o_pos.active),
		.i_dot        (i_dot),
		.i_bank       (i_bank),
		.i_pal_wr_stb (i_pal_wr_stb),
		.i_pal_wr     (i_pal_wr),
		.o_rgb        (o_rgb),
		.o_timing     (t4)
	);

	// Syncs leave with the colour
	assign o_hsync_n = t4.hsync_n;
	assign o_vsync_n = t4.vsync_n;
	// Composite low when either is low
	assign o_csync_n = t4.hsync_n & t4.vsync_n;

endmodule

`default_nettype wire

// File: clut_palette.sv
`default_nettype none

`include "vidgen_defines.svh"

module clut_palette (
	input  wire logic                       i_clk,
	input  wire logic                       i_rst_n,
	input  wire vidgen_pkg::video_timing_t  i_timing,
	input  wire logic                       i_active,
	input  wire logic [`VID_DOT_W-1:0]      i_dot,
	input  wire logic                       i_bank,
	input  wire logic                       i_pal_wr_stb,
	input  wire vidgen_pkg::pal_wr_t        i_pal_wr,
	output vidgen_pkg::rgb_t                o_rgb,
	output vidgen_pkg::video_timing_t       o_timing
);

	import vidgen_pkg::*;

	// Two banks of 256 colours
	localparam int PAL_DEPTH = 1 << `VID_PAL_AW;

	rgb_t                   pal_mem [PAL_DEPTH];
	logic [`VID_PAL_AW-1:0] rd_addr;
	rgb_t                   rd_data;

	////////////////////
	// Palette write
	////////////////////

	// Stands in for the colour PROMs
	// Writes land even while in reset, contents never cleared
	always_ff @(posedge i_clk) begin
		if (i_pal_wr_stb)
			pal_mem[i_pal_wr.addr] <= i_pal_wr.color;
	end

	////////////////////
	// Lookup
	////////////////////

	// Bank selects the upper half
	assign rd_addr = {i_bank, i_dot};

	// Async read, so a write one cycle earlier is already visible
	assign rd_data = pal_mem[rd_addr];

	// Output register
	// Inactive dots forced black, this is the blanking clamp
	// Timing follows one cycle behind, same as the colour
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_rgb    <= '0;
			o_timing <= '{hsync_n: 1'b0, vsync_n: 1'b0, hblank: 1'b1, vblank: 1'b1};
		end else begin
			o_rgb    <= i_active ? rd_data : '0;
			o_timing <= i_timing;
		end
	end

endmodule

`default_nettype wire

// File: blanking_to_count.sv
`default_nettype none

`include "vidgen_defines.svh"

module blanking_to_count (
	input  wire logic                       i_clk,
	input  wire logic                       i_rst_n,
	input  wire vidgen_pkg::video_timing_t  i_timing,
	output vidgen_pkg::video_timing_t       o_timing,
	output vidgen_pkg::video_pos_t          o_pos,
	output logic                            o_locked
);

	import vidgen_pkg::*;

	// Expected visible size
	localparam logic [`VID_CNT_W-1:0] ACT_COLS = `VID_CNT_W'(`VID_ACTIVE_COLS);
	localparam logic [`VID_CNT_W-1:0] ACT_ROWS = `VID_CNT_W'(`VID_ACTIVE_ROWS);
	localparam logic [`VID_CNT_W-1:0] CNT_MAX  = '1;

	lock_state_e           state_q;
	lock_state_e           state_nxt;
	logic                  vsync_prev;
	logic                  hblank_prev;
	logic                  v_edge;
	logic                  hb_rise;
	logic                  in_active;
	logic                  locked;
	logic                  frame_ok;
	logic                  width_err;
	logic [`VID_CNT_W-1:0] dot_cnt;
	logic [`VID_CNT_W-1:0] row_cnt;
	logic [`VID_CNT_W-1:0] meas_rows;

	// Frame starts on vsync fall, line ends on hblank rise
	assign v_edge    = vsync_prev & ~i_timing.vsync_n;
	assign hb_rise   = ~hblank_prev & i_timing.hblank;
	assign in_active = ~i_timing.hblank & ~i_timing.vblank;
	assign locked    = (state_q == LOCK_LOCKED);
	assign o_locked  = locked;

	// Every line had the right width and the line count matches
	assign frame_ok = ~width_err && (meas_rows == ACT_ROWS);

	////////////////////
	// Lock FSM
	////////////////////

	always_comb begin
		state_nxt = state_q;
		case (state_q)
			LOCK_SEARCH: begin
				// Measurement starts at this edge
				if (v_edge)
					state_nxt = LOCK_WAIT_FRAME;
			end
			LOCK_WAIT_FRAME: begin
				// Bad frame just restarts the measurement
				if (v_edge && frame_ok)
					state_nxt = LOCK_LOCKED;
			end
			LOCK_LOCKED: begin
				if (v_edge && !frame_ok)
					state_nxt = LOCK_SEARCH;
			end
			default: state_nxt = LOCK_SEARCH;
		endcase
	end

	////////////////////
	// Counters, outputs
	////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_q     <= LOCK_SEARCH;
			// First low vsync after reset counts as an edge
			vsync_prev  <= 1'b1;
			hblank_prev <= 1'b1;
			dot_cnt     <= '0;
			row_cnt     <= '0;
			meas_rows   <= '0;
			width_err   <= 1'b0;
			o_timing    <= '{hsync_n: 1'b0, vsync_n: 1'b0, hblank: 1'b1, vblank: 1'b1};
			o_pos       <= '0;
		end else begin
			state_q     <= state_nxt;
			vsync_prev  <= i_timing.vsync_n;
			hblank_prev <= i_timing.hblank;

			// Dots in current line, cleared in blanking
			if (!in_active)
				dot_cnt <= '0;
			else if (dot_cnt != CNT_MAX)
				dot_cnt <= dot_cnt + 1'b1;

			// Held at zero through vblank, steps at end of each line
			if (i_timing.vblank)
				row_cnt <= '0;
			else if (hb_rise)
				row_cnt <= row_cnt + 1'b1;

			// Per-frame size measurement
			if (v_edge) begin
				meas_rows <= '0;
				width_err <= 1'b0;
			end else if (hb_rise && !i_timing.vblank) begin
				if (meas_rows != CNT_MAX)
					meas_rows <= meas_rows + 1'b1;
				// dot_cnt still holds the finished line here
				if (dot_cnt != ACT_COLS)
					width_err <= 1'b1;
			end

			// Position in step with the delayed timing
			o_timing     <= i_timing;
			o_pos.active <= locked & in_active;
			o_pos.col    <= (locked && in_active) ? dot_cnt : '0;
			o_pos.row    <= (locked && in_active) ? row_cnt : '0;
		end
	end

endmodule

`default_nettype wire

// File: sync_to_blanking.sv
`default_nettype none

`include "vidgen_defines.svh"

module sync_to_blanking (
	input  wire logic                       i_clk,
	input  wire logic                       i_rst_n,
	input  wire vidgen_pkg::video_timing_t  i_timing,
	output vidgen_pkg::video_timing_t       o_timing
);

	// Visible window, counted from the sync falls
	localparam logic [`VID_CNT_W-1:0] H_ACT_START = `VID_CNT_W'(`VID_HSYNC_W + `VID_HBP);
	localparam logic [`VID_CNT_W-1:0] H_ACT_END   =
		`VID_CNT_W'(`VID_HSYNC_W + `VID_HBP + `VID_ACTIVE_COLS);
	localparam logic [`VID_CNT_W-1:0] V_ACT_START = `VID_CNT_W'(`VID_VSYNC_W + `VID_VBP);
	localparam logic [`VID_CNT_W-1:0] V_ACT_END   =
		`VID_CNT_W'(`VID_VSYNC_W + `VID_VBP + `VID_ACTIVE_ROWS);
	localparam logic [`VID_CNT_W-1:0] CNT_MAX     = '1;

	logic                  hsync_prev;
	logic                  vsync_prev;
	logic                  h_fall;
	logic                  v_fall;
	logic                  v_seen_q;
	logic                  v_seen;
	logic                  h_vis;
	logic                  v_vis;
	logic [`VID_CNT_W-1:0] col_q;
	logic [`VID_CNT_W-1:0] row_q;
	logic [`VID_CNT_W-1:0] col_cur;
	logic [`VID_CNT_W-1:0] row_cur;

	////////////////////
	// Edge detect
	////////////////////

	// Prev regs park high, so the low syncs out of reset give the first edges
	assign h_fall = hsync_prev & ~i_timing.hsync_n;
	assign v_fall = vsync_prev & ~i_timing.vsync_n;
	// Blanking only trusted once a frame start was seen
	assign v_seen = v_seen_q | v_fall;

	////////////////////
	// Rebuilt position
	////////////////////

	// Position of the incoming sample
	// Both counters saturate when no sync arrives
	always_comb begin
		col_cur = col_q;
		if (h_fall)
			col_cur = '0;
		else if (col_q != CNT_MAX)
			col_cur = col_q + 1'b1;
		row_cur = row_q;
		if (v_fall)
			row_cur = '0;
		else if (h_fall && row_q != CNT_MAX)
			row_cur = row_q + 1'b1;
	end

	// Inside the porches on each axis
	assign h_vis = (col_cur >= H_ACT_START) && (col_cur < H_ACT_END);
	assign v_vis = (row_cur >= V_ACT_START) && (row_cur < V_ACT_END);

	////////////////////
	// Output register
	////////////////////

	// Syncs pass through one stage, blanks computed for the same sample
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			hsync_prev <= 1'b1;
			vsync_prev <= 1'b1;
			v_seen_q   <= 1'b0;
			col_q      <= '0;
			row_q      <= '0;
			o_timing   <= '{hsync_n: 1'b0, vsync_n: 1'b0, hblank: 1'b1, vblank: 1'b1};
		end else begin
			hsync_prev       <= i_timing.hsync_n;
			vsync_prev       <= i_timing.vsync_n;
			v_seen_q         <= v_seen;
			col_q            <= col_cur;
			row_q            <= row_cur;
			o_timing.hsync_n <= i_timing.hsync_n;
			o_timing.vsync_n <= i_timing.vsync_n;
			// Held high until the first vsync fall
			o_timing.hblank  <= ~(v_seen && h_vis);
			o_timing.vblank  <= ~(v_seen && v_vis);
		end
	end

endmodule

`default_nettype wire

// File: sync_pulse_gen.sv
`default_nettype none

`include "vidgen_defines.svh"

module sync_pulse_gen (
	input  wire logic                  i_clk,
	input  wire logic                  i_rst_n,
	output vidgen_pkg::video_timing_t  o_timing
);

	// Last count of each counter before wrap
	localparam logic [`VID_CNT_W-1:0] COL_LAST = `VID_CNT_W'(`VID_TOTAL_COLS - 1);
	localparam logic [`VID_CNT_W-1:0] ROW_LAST = `VID_CNT_W'(`VID_TOTAL_ROWS - 1);
	// Pulse ends at these counts
	localparam logic [`VID_CNT_W-1:0] HSYNC_END = `VID_CNT_W'(`VID_HSYNC_W);
	localparam logic [`VID_CNT_W-1:0] VSYNC_END = `VID_CNT_W'(`VID_VSYNC_W);

	logic [`VID_CNT_W-1:0] col_q;
	logic [`VID_CNT_W-1:0] row_q;
	logic [`VID_CNT_W-1:0] col_nxt;
	logic [`VID_CNT_W-1:0] row_nxt;

	////////////////////
	// Raster counters
	////////////////////

	// Row steps when the line wraps
	always_comb begin
		col_nxt = col_q + 1'b1;
		row_nxt = row_q;
		if (col_q == COL_LAST) begin
			col_nxt = '0;
			if (row_q == ROW_LAST)
				row_nxt = '0;
			else
				row_nxt = row_q + 1'b1;
		end
	end

	////////////////////
	// Sync pulses
	////////////////////

	// Compare on the next count so the pulse lines up with col_q and row_q
	// Reset parks at col 0, row 0, both syncs low
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			col_q    <= '0;
			row_q    <= '0;
			o_timing <= '0;
		end else begin
			col_q            <= col_nxt;
			row_q            <= row_nxt;
			// Low for the first columns of every line
			o_timing.hsync_n <= (col_nxt >= HSYNC_END);
			// Low for the first lines of every frame
			o_timing.vsync_n <= (row_nxt >= VSYNC_END);
			// No blanking at this stage
			o_timing.hblank  <= 1'b0;
			o_timing.vblank  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: vidgen_pkg.sv
`default_nettype none

`include "vidgen_defines.svh"

package vidgen_pkg;

	////////////////////
	// Raster timing
	////////////////////

	// Sync pulses are active low, blanks active high
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank;
		logic vblank;
	} video_timing_t;

	// Position inside the visible window
	// Col and row stay zero outside it
	typedef struct packed {
		logic                  active;
		logic [`VID_CNT_W-1:0] col;
		logic [`VID_CNT_W-1:0] row;
	} video_pos_t;

	////////////////////
	// Colour
	////////////////////

	// One palette entry
	typedef struct packed {
		logic [`VID_COMP_W-1:0] red;
		logic [`VID_COMP_W-1:0] green;
		logic [`VID_COMP_W-1:0] blue;
	} rgb_t;

	// Palette write, bank bit in addr MSB
	typedef struct packed {
		logic [`VID_PAL_AW-1:0] addr;
		rgb_t                   color;
	} pal_wr_t;

	// Frame lock tracker
	typedef enum logic [1:0] {
		LOCK_SEARCH,
		LOCK_WAIT_FRAME,
		LOCK_LOCKED
	} lock_state_e;

endpackage

`default_nettype wire

// File: vidgen_defines.svh
`ifndef VIDGEN_DEFINES_SVH
`define VIDGEN_DEFINES_SVH

////////////////////
// Frame geometry
////////////////////

// Full raster including blanking
`define VID_TOTAL_COLS 384
`define VID_TOTAL_ROWS 288

// Visible window
`define VID_ACTIVE_COLS 288
`define VID_ACTIVE_ROWS 224

// Horizontal sync and porches, in dots
`define VID_HSYNC_W 32
`define VID_HBP 32
`define VID_HFP 32

// Vertical sync and porches, in lines
`define VID_VSYNC_W 8
`define VID_VBP 8
`define VID_VFP 48

////////////////////
// Data widths
////////////////////

// Shared by every column and row counter
`define VID_CNT_W 10
// Per colour component
`define VID_COMP_W 4
// Dot colour index
`define VID_DOT_W 8
// Palette address, bank bit on top of the dot
`define VID_PAL_AW 9

`endif
